/* bram_init.hex */
// One 32-bit word per line, word address 0 to 63 in order
// Bytes from the top: 0x10 + addr, addr, 0xFF - addr, addr ^ 0x3C
1000FF3C
1101FE3D
1202FD3E
1303FC3F
1404FB38
1505FA39
1606F93A
1707F83B
1808F734
1909F635
1A0AF536
1B0BF437
1C0CF330
1D0DF231
1E0EF132
1F0FF033
2010EF2C
2111EE2D
2212ED2E
2313EC2F
2414EB28
2515EA29
2616E92A
2717E82B
2818E724
2919E625
2A1AE526
2B1BE427
2C1CE320
2D1DE221
2E1EE122
2F1FE023
3020DF1C
3121DE1D
3222DD1E
3323DC1F
3424DB18
3525DA19
3626D91A
3727D81B
3828D714
3929D615
3A2AD516
3B2BD417
3C2CD310
3D2DD211
3E2ED112
3F2FD013
4030CF0C
4131CE0D
4232CD0E
4333CC0F
4434CB08
4535CA09
4636C90A
4737C80B
4838C704
4939C605
4A3AC506
4B3BC407
4C3CC300
4D3DC201
4E3EC102
4F3FC003

/* tb.f */
verilog/bram_reader_pkg.sv
verilog/ar_decode.sv
verilog/bram_array.sv
verilog/r_result.sv
verilog/axi_bram_reader.sv
verif/tb_axi_bram_reader.sv

/* Makefile */
# Verilator build and run for the AXI4-Lite block RAM reader

SIM       := verilator
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_axi_bram_reader
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_axi_bram_reader.sv */
// ##########################################################
// Directed testbench for the AXI4-Lite block RAM reader:
// AXI master tasks, reference RAM image and checks
// ##########################################################

`timescale 1ns/1ps

module tb_axi_bram_reader import bram_reader_pkg::*; ();

  // Cycles any wait loop may spend before giving up
  localparam int wait_limit = 32;

  logic    aclk;
  logic    aresetn;
  axi_ar_t s_axi_ar;
  logic    s_axi_arvalid;
  logic    s_axi_arready;
  axi_r_t  s_axi_r;
  logic    s_axi_rvalid;
  logic    s_axi_rready;

  // Reference copy of the RAM image
  logic [axi_data_width-1:0] model_mem [0:bram_depth-1];

  int check_errors;
  int timeout_errors;

  axi_bram_reader dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_ar      (s_axi_ar),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_r       (s_axi_r),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  // 4 ns clock
  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // Word at byte address bits 7 to 2 so upper bits wrap away
  function automatic logic [31:0] expected_word(input logic [15:0] addr);
    return model_mem[addr[7:2]];
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      check_errors++;
      $display("CHECK FAILED %s %s: expected %08h actual %08h", test, what, exp, act);
    end
  endtask

  // Called at a rising edge and returns at the edge of the AR transfer
  // arvalid is left high so a following send goes out back to back
  task automatic ar_send(input string test, input logic [15:0] addr,
                         output logic rvalid_seen, output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b1;
    s_axi_ar      <= '{araddr: addr, arprot: 3'b000};
    s_axi_arvalid <= 1'b1;
    @(negedge aclk);
    while (ok && s_axi_arready !== 1'b1) begin
      cycles++;
      if (cycles > wait_limit) begin
        timeout_errors++;
        ok = 1'b0;
        $display("ERROR %s: arready stayed low for %0d cycles", test, wait_limit);
      end else begin
        @(negedge aclk);
      end
    end
    // rvalid as seen just before the transfer edge
    rvalid_seen = s_axi_rvalid;
    @(posedge aclk);
  endtask

  // Returns at a falling edge with rvalid high
  task automatic wait_rvalid(input string test, output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b1;
    @(negedge aclk);
    while (ok && s_axi_rvalid !== 1'b1) begin
      cycles++;
      if (cycles > wait_limit) begin
        timeout_errors++;
        ok = 1'b0;
        $display("ERROR %s: rvalid did not rise within %0d cycles", test, wait_limit);
      end else begin
        @(negedge aclk);
      end
    end
  endtask

  task automatic test_reset();
    @(negedge aclk);
    check_value("test_reset", "arready", 32'd1, 32'(s_axi_arready));
    check_value("test_reset", "rvalid", 32'd0, 32'(s_axi_rvalid));
  endtask

  task automatic test_single_read();
    logic [15:0] addrs [6];
    logic        rv_before;
    bit          ok;
    addrs[0] = 16'h0000;
    addrs[1] = 16'h00FC;
    addrs[2] = 16'h0046;
    for (int i = 3; i < 6; i++) begin
      addrs[i] = 16'($urandom);
    end
    @(posedge aclk);
    s_axi_rready <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      ar_send("test_single_read", addrs[i], rv_before, ok);
      s_axi_arvalid <= 1'b0;
      // With nothing pending rvalid is up one cycle after the transfer
      @(negedge aclk);
      check_value("test_single_read", "rvalid before", 32'd0, 32'(rv_before));
      check_value("test_single_read", "rvalid", 32'd1, 32'(s_axi_rvalid));
      check_value("test_single_read", "rdata", expected_word(addrs[i]), s_axi_r.rdata);
      // AXI encodes OKAY as 0
      check_value("test_single_read", "rresp", 32'd0, 32'(s_axi_r.rresp));
      @(posedge aclk);
    end
  endtask

  task automatic test_stall_hold();
    logic [15:0] addr;
    logic [31:0] held;
    logic        rv_before;
    int          stall;
    bit          ok;
    for (int n = 0; n < 4; n++) begin
      addr  = 16'($urandom);
      stall = 1 + int'($urandom % 8);
      @(posedge aclk);
      s_axi_rready <= 1'b0;
      ar_send("test_stall_hold", addr, rv_before, ok);
      s_axi_arvalid <= 1'b0;
      wait_rvalid("test_stall_hold", ok);
      held = s_axi_r.rdata;
      check_value("test_stall_hold", "rdata", expected_word(addr), held);
      // R held off for the random stall length
      for (int c = 1; c < stall; c++) begin
        @(negedge aclk);
        check_value("test_stall_hold", "rvalid held", 32'd1, 32'(s_axi_rvalid));
        check_value("test_stall_hold", "rdata held", held, s_axi_r.rdata);
      end
      @(posedge aclk);
      s_axi_rready <= 1'b1;
      @(negedge aclk);
      check_value("test_stall_hold", "rvalid at accept", 32'd1, 32'(s_axi_rvalid));
      check_value("test_stall_hold", "rdata at accept", expected_word(addr), s_axi_r.rdata);
      @(posedge aclk);
    end
  endtask

  task automatic test_queue_during_stall();
    logic [15:0] first_addr;
    logic [15:0] second_addr;
    logic        rv_before;
    bit          ok;
    first_addr  = 16'h0010;
    second_addr = 16'h0124;
    @(posedge aclk);
    s_axi_rready <= 1'b0;
    ar_send("test_queue_during_stall", first_addr, rv_before, ok);
    // Second request goes into the queue while R is stalled
    ar_send("test_queue_during_stall", second_addr, rv_before, ok);
    s_axi_arvalid <= 1'b0;
    check_value("test_queue_during_stall", "rvalid at second AR", 32'd1, 32'(rv_before));
    for (int c = 0; c < 3; c++) begin
      @(negedge aclk);
      check_value("test_queue_during_stall", "arready full", 32'd0, 32'(s_axi_arready));
      check_value("test_queue_during_stall", "rvalid", 32'd1, 32'(s_axi_rvalid));
      check_value("test_queue_during_stall", "first rdata", expected_word(first_addr),
                  s_axi_r.rdata);
    end
    @(posedge aclk);
    s_axi_rready <= 1'b1;
    @(negedge aclk);
    check_value("test_queue_during_stall", "first rdata", expected_word(first_addr),
                s_axi_r.rdata);
    @(posedge aclk);
    // Queued response right after the first one completes
    @(negedge aclk);
    check_value("test_queue_during_stall", "second rvalid", 32'd1, 32'(s_axi_rvalid));
    check_value("test_queue_during_stall", "second rdata", expected_word(second_addr),
                s_axi_r.rdata);
    check_value("test_queue_during_stall", "arready drained", 32'd1, 32'(s_axi_arready));
    @(posedge aclk);
    @(negedge aclk);
    check_value("test_queue_during_stall", "rvalid idle", 32'd0, 32'(s_axi_rvalid));
  endtask

  task automatic test_burst_random();
    logic [15:0] addrs [40];
    logic        rv_before;
    bit          send_ok;
    bit          recv_ok;
    // Two fixed addresses past 256 bytes and the rest random
    addrs[0] = 16'h0104;
    addrs[1] = 16'hFFFC;
    for (int i = 2; i < 40; i++) begin
      addrs[i] = 16'($urandom);
    end
    @(posedge aclk);
    s_axi_rready <= 1'b1;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          ar_send("test_burst_random", addrs[i], rv_before, send_ok);
        end
        s_axi_arvalid <= 1'b0;
      end
      begin
        for (int j = 0; j < 40; j++) begin
          wait_rvalid("test_burst_random", recv_ok);
          check_value("test_burst_random", "rdata", expected_word(addrs[j]), s_axi_r.rdata);
          check_value("test_burst_random", "rresp", 32'd0, 32'(s_axi_r.rresp));
          @(posedge aclk);
        end
      end
    join
  endtask

  initial begin
    void'($urandom(75));
    $readmemh(bram_init_file, model_mem);
    check_errors   = 0;
    timeout_errors = 0;
    aresetn        <= 1'b0;
    s_axi_ar       <= '0;
    s_axi_arvalid  <= 1'b0;
    s_axi_rready   <= 1'b0;
    // Reset held for two cycles
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    test_reset();
    test_single_read();
    test_stall_hold();
    test_queue_during_stall();
    test_burst_random();
    repeat (2) @(posedge aclk);
    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/axi_bram_reader.sv */
// ##########################################################
// Read-only AXI4-Lite slave serving words from block RAM
// ##########################################################

`timescale 1ns/1ps

module axi_bram_reader import bram_reader_pkg::*; (
  input  logic    aclk,
  input  logic    aresetn,

  // AR channel
  input  axi_ar_t s_axi_ar,
  input  logic    s_axi_arvalid,
  output logic    s_axi_arready,

  // R channel
  output axi_r_t  s_axi_r,
  output logic    s_axi_rvalid,
  input  logic    s_axi_rready
);

  // Decoder to RAM and result stage
  bram_addr_t                rd_addr;
  logic                      rd_issue;

  // RAM output, one cycle behind rd_addr
  logic [axi_data_width-1:0] rd_data;

  // Result stage back to decoder
  logic                      r_free;

  // AR decode and request queue
  ar_decode u_ar_decode (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .ar       (s_axi_ar),
    .arvalid  (s_axi_arvalid),
    .arready  (s_axi_arready),
    .r_free   (r_free),
    .rd_issue (rd_issue),
    .rd_addr  (rd_addr)
  );

  // Word RAM read
  bram_array u_bram_array (
    .aclk    (aclk),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // R channel response
  r_result u_r_result (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .rd_issue (rd_issue),
    .rd_data  (rd_data),
    .r        (s_axi_r),
    .rvalid   (s_axi_rvalid),
    .rready   (s_axi_rready),
    .r_free   (r_free)
  );

endmodule

/* verilog/r_result.sv */
// ##########################################################
// R channel stage: valid state, data pass-through and
// slot-free signal back to the decoder
// ##########################################################

`timescale 1ns/1ps

module r_result import bram_reader_pkg::*; (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      rd_issue,
  input  logic [axi_data_width-1:0] rd_data,
  output axi_r_t                    r,
  output logic                      rvalid,
  input  logic                      rready,
  output logic                      r_free
);

  logic rvalid_q;
  logic r_done;

  assign rvalid = rvalid_q;

  // Response handed over this cycle
  assign r_done = rvalid_q & rready;

  // Slot usable when empty or emptying now
  assign r_free = ~rvalid_q | rready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rvalid_q <= 1'b0;
    end else begin
      if (rd_issue) begin
        // New read lands one cycle later, even on completion
        rvalid_q <= 1'b1;
      end else if (r_done) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // RAM output goes straight out with OKAY
  assign r.rdata = rd_data;
  assign r.rresp = resp_okay;

  // Valid stays up until the master takes it
  a_rvalid_hold : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (rvalid && !rready) |=> rvalid
  ) else $error("r_result: rvalid dropped during stall");

  // Payload frozen while stalled, relies on the held RAM address
  a_rdata_hold : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (rvalid && !rready) |=> $stable(r)
  ) else $error("r_result: R payload changed during stall");

  // A new response always comes from an issue one cycle before
  a_rvalid_cause : assert property (
    @(posedge aclk) disable iff (!aresetn)
    $rose(rvalid) |-> $past(rd_issue)
  ) else $error("r_result: rvalid rose without a prior issue");

  // rvalid is a known value once out of reset
  a_rvalid_known : assert property (
    @(posedge aclk) disable iff (!aresetn)
    !$isunknown(rvalid)
  ) else $error("r_result: rvalid is X or Z");

endmodule

/* verilog/bram_array.sv */
// ##########################################################
// Synchronous-read word RAM loaded from the hex image
// ##########################################################

`timescale 1ns/1ps

module bram_array import bram_reader_pkg::*; (
  input  logic                      aclk,
  input  bram_addr_t                rd_addr,
  output logic [axi_data_width-1:0] rd_data
);

  // Word storage, read only in this design
  logic [axi_data_width-1:0] mem [0:bram_depth-1];

  // Registered read address, block RAM style
  bram_addr_t addr_q;

  // Contents come from the image file at start-up
  initial begin
    $readmemh(bram_init_file, mem);
  end

  // Address sampled on every clock
  always_ff @(posedge aclk) begin
    addr_q <= rd_addr;
  end

  // Output follows the registered address,
  // so a held address means held data
  assign rd_data = mem[addr_q];

endmodule

/* verilog/ar_decode.sv */
// ##########################################################
// AR channel decoder with a one-entry request queue and
// held RAM word address
// ##########################################################

`timescale 1ns/1ps

module ar_decode import bram_reader_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,
  input  axi_ar_t    ar,
  input  logic       arvalid,
  output logic       arready,
  input  logic       r_free,
  output logic       rd_issue,
  output bram_addr_t rd_addr
);

  // Queue entry for a request taken during an R stall
  logic       q_valid;
  bram_addr_t q_addr;

  // Last address sent to the RAM
  bram_addr_t addr_q;

  logic       ar_fire;
  bram_addr_t new_addr;
  bram_addr_t issue_addr;

  // Accept whenever the queue has room
  assign arready = ~q_valid;
  assign ar_fire = arvalid & arready;

  // Word address, upper bits dropped so reads wrap
  assign new_addr = ar.araddr[addr_lsb +: bram_addr_width];

  // Queued request goes first, otherwise the incoming one
  assign rd_issue   = r_free & (q_valid | ar_fire);
  assign issue_addr = q_valid ? q_addr : new_addr;

  // New address in the issue cycle, held one otherwise
  assign rd_addr = rd_issue ? issue_addr : addr_q;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      q_valid <= 1'b0;
    end else begin
      if (q_valid && r_free) begin
        // Queued request drains
        q_valid <= 1'b0;
      end else if (ar_fire && !r_free) begin
        // R busy, park the request
        q_valid <= 1'b1;
      end
    end
  end

  // Queue payload, only meaningful with q_valid
  always_ff @(posedge aclk) begin
    if (ar_fire && !r_free) begin
      q_addr <= new_addr;
    end
  end

  // Held address keeps the RAM output steady in a stall
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      addr_q <= '0;
    end else if (rd_issue) begin
      addr_q <= issue_addr;
    end
  end

  // A parked request is kept intact until R frees up
  a_queue_single : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (q_valid && !r_free) |=> (q_valid && $stable(q_addr))
  ) else $error("ar_decode: queued request lost or overwritten");

  // After a stalled accept the master sees arready low
  a_queue_full_block : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (ar_fire && !r_free) |=> !(arvalid && arready)
  ) else $error("ar_decode: AR transfer while queue full");

  // RAM address moves only on an issue
  a_addr_hold : assert property (
    @(posedge aclk) disable iff (!aresetn)
    !rd_issue |-> $stable(rd_addr)
  ) else $error("ar_decode: rd_addr changed without rd_issue");

endmodule

/* verilog/bram_reader_pkg.sv */
// ##########################################################
// Shared widths, response codes and channel structs for
// the AXI4-Lite block RAM reader
// ##########################################################

package bram_reader_pkg;

  // AXI side widths
  localparam int axi_data_width = 32;
  localparam int axi_addr_width = 16;
  localparam int axi_prot_width = 3;
  localparam int axi_resp_width = 2;

  // Word RAM geometry, 64 words of 32 bits
  localparam int bram_addr_width = 6;
  localparam int bram_depth      = 1 << bram_addr_width;

  // Byte offset bits below the word address
  localparam int addr_lsb = 2;

  // Only OKAY is ever returned
  localparam logic [axi_resp_width-1:0] resp_okay = 2'b00;

  // Initial RAM image, also read by the testbench model
  localparam string bram_init_file = "bram_init.hex";

  // Read address channel payload
  typedef struct packed {
    logic [axi_addr_width-1:0] araddr;
    // Protection bits are taken but have no effect
    logic [axi_prot_width-1:0] arprot;
  } axi_ar_t;

  // Read data channel payload, 34 bits
  typedef struct packed {
    logic [axi_data_width-1:0] rdata;
    logic [axi_resp_width-1:0] rresp;
  } axi_r_t;

  // Word address into the RAM
  typedef logic [bram_addr_width-1:0] bram_addr_t;

endpackage
